// ==== common/issue_pkg.sv ====
// Shared definitions for the decode and issue stage
// Widths, unit indices, opcode values and the ALU operation set

package issue_pkg;

    //////////////////////////////
    // Data widths
    typedef logic [31:0] inst_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  inst_id_t;

    //////////////////////////////
    // Execution units
    localparam int NUM_UNITS = 2;
    localparam int ALU_ID    = 0;
    localparam int MUL_ID    = 1;

    // Multiplier depth, issue to writeback
    localparam int MUL_STAGES = 3;

    //////////////////////////////
    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ALU operations, PASS_B serves LUI
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    //////////////////////////////
    // Exception causes
    typedef logic [3:0] exc_code_t;
    localparam exc_code_t ILLEGAL_INST = 4'd2;

endpackage

// ==== logic/inst_buffer.sv ====
// Instruction buffer at the decode input
// Circular FIFO, each pop hands one credit back to the source

`timescale 1ns/1ps

module inst_buffer import issue_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  inst_t       in_inst,
    input  inst_id_t    in_id,
    input  logic [31:0] in_pc,
    output logic        out_valid,
    output inst_t       out_inst,
    output inst_id_t    out_id,
    output logic [31:0] out_pc,
    input  logic        pop,
    output logic        credit
);

    localparam int PTR_W = $clog2(DEPTH);

    inst_t       inst_mem [DEPTH];
    inst_id_t    id_mem [DEPTH];
    logic [31:0] pc_mem [DEPTH];

    // Extra pointer bit tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           do_pop;

    assign out_valid = wr_ptr != rd_ptr;
    assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                       (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign do_pop    = out_valid & pop;
    assign credit    = do_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            inst_mem[wr_ptr[PTR_W-1:0]] <= in_inst;
            id_mem[wr_ptr[PTR_W-1:0]]   <= in_id;
            pc_mem[wr_ptr[PTR_W-1:0]]   <= in_pc;
        end
    end

    // Head entry, visible the cycle after its write
    assign out_inst = inst_mem[rd_ptr[PTR_W-1:0]];
    assign out_id   = id_mem[rd_ptr[PTR_W-1:0]];
    assign out_pc   = pc_mem[rd_ptr[PTR_W-1:0]];

    // Source must hold back without a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !full);

endmodule

// ==== issue/decode_and_issue.sv ====
// Decode and issue stage
// Decodes into unit, operand and immediate fields, holds one issue register,
// waits on the scoreboard and units, and raises illegal-instruction exceptions

`timescale 1ns/1ps

module decode_and_issue import issue_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        buf_valid,
    input  inst_t       buf_inst,
    input  inst_id_t    buf_id,
    input  logic [31:0] buf_pc,
    input  logic        rs1_busy,
    input  logic        rs2_busy,
    input  data_t       rs1_data,
    input  data_t       rs2_data,
    input  logic        alu_ready,
    input  logic        mul_claim_next,
    input  logic        exc_ack,
    output logic        decode_advance,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    output logic        set_valid,
    output reg_addr_t   set_addr,
    output logic        alu_issue,
    output logic        mul_issue,
    output alu_op_t     issue_op,
    output data_t       issue_a,
    output data_t       issue_b,
    output reg_addr_t   issue_rd,
    output inst_id_t    issue_id,
    output logic        exc_valid,
    output exc_code_t   exc_code,
    output inst_id_t    exc_id,
    output data_t       exc_tval
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    logic [NUM_UNITS-1:0] dec_unit;
    logic                 dec_uses_rs1;
    logic                 dec_uses_rs2;
    logic                 dec_use_imm;
    logic                 dec_illegal;
    alu_op_t              dec_op;
    data_t                dec_imm;

    logic                 iss_valid;
    inst_t                iss_inst;
    logic [NUM_UNITS-1:0] iss_unit;
    logic                 iss_uses_rs1;
    logic                 iss_uses_rs2;
    logic                 iss_uses_rd;
    logic                 iss_use_imm;
    data_t                iss_imm;
    logic                 exc_pending;

    logic                 issue_stage_ready;
    logic                 operands_ready;
    logic                 waw_hold;
    logic                 can_issue;
    logic                 new_exc;
    logic                 mul_v1;
    reg_addr_t            mul_rd1;
    reg_addr_t            mul_rd2;

    //////////////////////////////
    // Decode
    always_comb begin
        dec_unit     = '0;
        dec_uses_rs1 = 1'b0;
        dec_uses_rs2 = 1'b0;
        dec_use_imm  = 1'b0;
        dec_op       = ALU_ADD;
        dec_imm      = {{20{buf_inst[31]}}, buf_inst[31:20]};
        case (buf_inst[6:0])
            OPC_OP: begin
                dec_uses_rs1     = 1'b1;
                dec_uses_rs2     = 1'b1;
                dec_unit[ALU_ID] = 1'b1;
                case ({buf_inst[31:25], buf_inst[14:12]})
                    {F7_BASE, 3'b000}: dec_op = ALU_ADD;
                    {F7_ALT, 3'b000}:  dec_op = ALU_SUB;
                    {F7_BASE, 3'b111}: dec_op = ALU_AND;
                    {F7_BASE, 3'b110}: dec_op = ALU_OR;
                    {F7_BASE, 3'b100}: dec_op = ALU_XOR;
                    {F7_BASE, 3'b010}: dec_op = ALU_SLT;
                    {F7_MUL, 3'b000}: begin
                        dec_unit[ALU_ID] = 1'b0;
                        dec_unit[MUL_ID] = 1'b1;
                    end
                    default: dec_unit[ALU_ID] = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec_uses_rs1     = 1'b1;
                dec_use_imm      = 1'b1;
                dec_unit[ALU_ID] = 1'b1;
                case (buf_inst[14:12])
                    3'b000:  dec_op = ALU_ADD;
                    3'b111:  dec_op = ALU_AND;
                    3'b110:  dec_op = ALU_OR;
                    3'b100:  dec_op = ALU_XOR;
                    default: dec_unit[ALU_ID] = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec_use_imm      = 1'b1;
                dec_unit[ALU_ID] = 1'b1;
                dec_op           = ALU_PASS_B;
                dec_imm          = {buf_inst[31:12], 12'b0};
            end
            default: ;
        endcase
    end

    // No unit claims the encoding
    assign dec_illegal = ~|dec_unit;

    //////////////////////////////
    // Issue register
    assign issue_stage_ready = ~iss_valid | alu_issue | mul_issue | (exc_valid & exc_ack);
    assign decode_advance    = buf_valid & issue_stage_ready;

    always_ff @(posedge clk) begin
        if (issue_stage_ready) begin
            iss_inst     <= buf_inst;
            issue_id     <= buf_id;
            iss_unit     <= dec_unit;
            issue_op     <= dec_op;
            iss_imm      <= dec_imm;
            iss_use_imm  <= dec_use_imm;
            iss_uses_rs1 <= dec_uses_rs1;
            iss_uses_rs2 <= dec_uses_rs2;
            iss_uses_rd  <= ~dec_illegal & (buf_inst[11:7] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid   <= 1'b0;
            exc_pending <= 1'b0;
        end else if (issue_stage_ready) begin
            iss_valid   <= buf_valid;
            exc_pending <= buf_valid & dec_illegal;
        end
    end

    assign rs1_addr = iss_inst[19:15];
    assign rs2_addr = iss_inst[24:20];
    assign issue_rd = iss_inst[11:7];

    //////////////////////////////
    // Issue determination
    assign operands_ready = ~(iss_uses_rs1 & rs1_busy) & ~(iss_uses_rs2 & rs2_busy);

    // Destinations of multiplies still two and one cycles from writeback;
    // the stage-two valid is the multiplier's own claim
    always_ff @(posedge clk) begin
        if (rst)
            mul_v1 <= 1'b0;
        else
            mul_v1 <= mul_issue;
    end

    always_ff @(posedge clk) begin
        mul_rd1 <= issue_rd;
        mul_rd2 <= mul_rd1;
    end

    // A younger write must not overtake an older multiply
    assign waw_hold = iss_uses_rd & ((mul_v1 & (mul_rd1 == issue_rd)) |
                                     (mul_claim_next & (mul_rd2 == issue_rd)));

    assign can_issue = iss_valid & operands_ready & ~waw_hold & ~exc_pending;
    assign alu_issue = can_issue & iss_unit[ALU_ID] & alu_ready;
    assign mul_issue = can_issue & iss_unit[MUL_ID];

    assign issue_a = rs1_data;
    assign issue_b = iss_use_imm ? iss_imm : rs2_data;

    assign set_valid = (alu_issue | mul_issue) & iss_uses_rd;
    assign set_addr  = issue_rd;

    //////////////////////////////
    // Illegal instruction exception
    assign new_exc = iss_valid & exc_pending & ~exc_valid;

    always_ff @(posedge clk) begin
        if (rst)
            exc_valid <= 1'b0;
        else
            exc_valid <= (exc_valid & ~exc_ack) | new_exc;
    end

    always_ff @(posedge clk) begin
        if (new_exc) begin
            exc_code <= ILLEGAL_INST;
            exc_id   <= issue_id;
            exc_tval <= iss_inst;
        end
    end

    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(alu_issue && mul_issue));

    // Fetch side delivers word-aligned addresses only
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        buf_valid |-> buf_pc[1:0] == 2'b00);

endmodule

// ==== issue/reg_scoreboard.sv ====
// Register scoreboard
// One in-use bit per architectural register, set on issue, cleared on writeback

`timescale 1ns/1ps

module reg_scoreboard import issue_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      set_valid,
    input  reg_addr_t set_addr,
    input  logic      clr_valid,
    input  reg_addr_t clr_addr,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output logic      rs1_busy,
    output logic      rs2_busy
);

    logic [31:0] inuse;

    // Set after clear, so a new owner wins over a finishing one
    always_ff @(posedge clk) begin
        if (rst) begin
            inuse <= '0;
        end else begin
            if (clr_valid)
                inuse[clr_addr] <= 1'b0;
            if (set_valid && set_addr != '0)
                inuse[set_addr] <= 1'b1;
        end
    end

    // Writeback this cycle already frees the operand
    assign rs1_busy = inuse[rs1_addr] & ~(clr_valid & (clr_addr == rs1_addr));
    assign rs2_busy = inuse[rs2_addr] & ~(clr_valid & (clr_addr == rs2_addr));

    a_no_double_set: assert property (@(posedge clk) disable iff (rst)
        set_valid |-> !inuse[set_addr] || (clr_valid && clr_addr == set_addr));

endmodule

// ==== logic/regfile.sv ====
// Integer register file
// 32 entries, two combinational read ports with write-through, x0 is zero

`timescale 1ns/1ps

module regfile import issue_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  reg_addr_t waddr,
    input  data_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output data_t     rdata1,
    output data_t     rdata2
);

    data_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    // Same-cycle write is forwarded to the readers
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// ==== logic/alu_unit.sv ====
// Single-cycle integer ALU
// Result is registered and reaches the write port one cycle after issue

`timescale 1ns/1ps

module alu_unit import issue_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  alu_op_t   op,
    input  data_t     a,
    input  data_t     b,
    input  reg_addr_t rd,
    input  inst_id_t  id,
    input  logic      mul_claim_next,
    output logic      ready,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output inst_id_t  wb_id,
    output data_t     wb_data
);

    data_t result;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            // PASS_B for LUI
            default: result = b;
        endcase
    end

    // Write port belongs to the multiplier in the cycle after its claim
    assign ready = ~mul_claim_next;

    always_ff @(posedge clk) begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= issue_valid;
    end

    // Idle payload is zero so the two write ports merge by OR
    always_ff @(posedge clk) begin
        wb_rd   <= issue_valid ? rd : '0;
        wb_id   <= issue_valid ? id : '0;
        wb_data <= issue_valid ? result : '0;
    end

endmodule

// ==== logic/mul_unit.sv ====
// Pipelined 32-bit multiplier
// Operand, product and result stages, low word of the product written back

`timescale 1ns/1ps

module mul_unit import issue_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  data_t     a,
    input  data_t     b,
    input  reg_addr_t rd,
    input  inst_id_t  id,
    output logic      claim_next,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output inst_id_t  wb_id,
    output data_t     wb_data
);

    logic [MUL_STAGES-1:0] valid_q;
    reg_addr_t             rd_q [MUL_STAGES];
    inst_id_t              id_q [MUL_STAGES];
    data_t                 a_q;
    data_t                 b_q;
    data_t                 prod_q;
    data_t                 res_q;

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= '0;
        else
            valid_q <= {valid_q[MUL_STAGES-2:0], issue_valid};
    end

    always_ff @(posedge clk) begin
        a_q    <= a;
        b_q    <= b;
        prod_q <= a_q * b_q;
        // Zero when idle for the OR merge at the top
        res_q  <= valid_q[MUL_STAGES-2] ? prod_q : '0;
    end

    // Tag pipeline alongside the data
    always_ff @(posedge clk) begin
        rd_q[0] <= rd;
        id_q[0] <= id;
        for (int i = 1; i < MUL_STAGES - 1; i++) begin
            rd_q[i] <= rd_q[i-1];
            id_q[i] <= id_q[i-1];
        end
        rd_q[MUL_STAGES-1] <= valid_q[MUL_STAGES-2] ? rd_q[MUL_STAGES-2] : '0;
        id_q[MUL_STAGES-1] <= valid_q[MUL_STAGES-2] ? id_q[MUL_STAGES-2] : '0;
    end

    assign claim_next = valid_q[MUL_STAGES-2];
    assign wb_valid   = valid_q[MUL_STAGES-1];
    assign wb_rd      = rd_q[MUL_STAGES-1];
    assign wb_id      = id_q[MUL_STAGES-1];
    assign wb_data    = res_q;

endmodule

// ==== logic/issue_top.sv ====
// Decode and issue top level
// Instruction buffer, issue stage, scoreboard, register file, ALU and multiplier

`timescale 1ns/1ps

module issue_top import issue_pkg::*; #(
    parameter int DECODE_CREDITS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid,
    input  inst_t       inst,
    input  inst_id_t    inst_id,
    input  logic [31:0] inst_pc,
    input  logic        exc_ack,
    output logic        inst_credit,
    output logic        wb_valid,
    output reg_addr_t   wb_rd,
    output inst_id_t    wb_id,
    output data_t       wb_data,
    output logic        exc_valid,
    output exc_code_t   exc_code,
    output inst_id_t    exc_id,
    output data_t       exc_tval
);

    logic        buf_valid;
    inst_t       buf_inst;
    inst_id_t    buf_id;
    logic [31:0] buf_pc;
    logic        decode_advance;

    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    logic        rs1_busy;
    logic        rs2_busy;
    data_t       rs1_data;
    data_t       rs2_data;
    logic        set_valid;
    reg_addr_t   set_addr;

    logic        alu_issue;
    logic        mul_issue;
    alu_op_t     issue_op;
    data_t       issue_a;
    data_t       issue_b;
    reg_addr_t   issue_rd;
    inst_id_t    issue_id;
    logic        alu_ready;
    logic        mul_claim_next;

    logic        alu_wb_valid;
    reg_addr_t   alu_wb_rd;
    inst_id_t    alu_wb_id;
    data_t       alu_wb_data;
    logic        mul_wb_valid;
    reg_addr_t   mul_wb_rd;
    inst_id_t    mul_wb_id;
    data_t       mul_wb_data;

    //////////////////////////////
    // Front end
    inst_buffer #(.DEPTH(DECODE_CREDITS)) u_inst_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (inst_valid),
        .in_inst   (inst),
        .in_id     (inst_id),
        .in_pc     (inst_pc),
        .out_valid (buf_valid),
        .out_inst  (buf_inst),
        .out_id    (buf_id),
        .out_pc    (buf_pc),
        .pop       (decode_advance),
        .credit    (inst_credit)
    );

    decode_and_issue u_decode_and_issue (
        .clk            (clk),
        .rst            (rst),
        .buf_valid      (buf_valid),
        .buf_inst       (buf_inst),
        .buf_id         (buf_id),
        .buf_pc         (buf_pc),
        .rs1_busy       (rs1_busy),
        .rs2_busy       (rs2_busy),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .alu_ready      (alu_ready),
        .mul_claim_next (mul_claim_next),
        .exc_ack        (exc_ack),
        .decode_advance (decode_advance),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .set_valid      (set_valid),
        .set_addr       (set_addr),
        .alu_issue      (alu_issue),
        .mul_issue      (mul_issue),
        .issue_op       (issue_op),
        .issue_a        (issue_a),
        .issue_b        (issue_b),
        .issue_rd       (issue_rd),
        .issue_id       (issue_id),
        .exc_valid      (exc_valid),
        .exc_code       (exc_code),
        .exc_id         (exc_id),
        .exc_tval       (exc_tval)
    );

    //////////////////////////////
    // Register state
    reg_scoreboard u_reg_scoreboard (
        .clk       (clk),
        .rst       (rst),
        .set_valid (set_valid),
        .set_addr  (set_addr),
        .clr_valid (wb_valid),
        .clr_addr  (wb_rd),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_busy  (rs1_busy),
        .rs2_busy  (rs2_busy)
    );

    regfile u_regfile (
        .clk    (clk),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    //////////////////////////////
    // Execution units
    alu_unit u_alu_unit (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (alu_issue),
        .op             (issue_op),
        .a              (issue_a),
        .b              (issue_b),
        .rd             (issue_rd),
        .id             (issue_id),
        .mul_claim_next (mul_claim_next),
        .ready          (alu_ready),
        .wb_valid       (alu_wb_valid),
        .wb_rd          (alu_wb_rd),
        .wb_id          (alu_wb_id),
        .wb_data        (alu_wb_data)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (mul_issue),
        .a           (issue_a),
        .b           (issue_b),
        .rd          (issue_rd),
        .id          (issue_id),
        .claim_next  (mul_claim_next),
        .wb_valid    (mul_wb_valid),
        .wb_rd       (mul_wb_rd),
        .wb_id       (mul_wb_id),
        .wb_data     (mul_wb_data)
    );

    // Idle unit drives zeros, so OR is the merge
    assign wb_valid = alu_wb_valid | mul_wb_valid;
    assign wb_rd    = alu_wb_rd | mul_wb_rd;
    assign wb_id    = alu_wb_id | mul_wb_id;
    assign wb_data  = alu_wb_data | mul_wb_data;

    a_wb_no_collision: assert property (@(posedge clk) disable iff (rst)
        !(alu_wb_valid && mul_wb_valid));

endmodule

// ==== verif/issue_model.svh ====
// Reference model for the issue testbench
// Architectural registers executed in program order, expected result per id

`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// Instruction kinds drawn by the stimulus
localparam int K_ADD  = 0;
localparam int K_SUB  = 1;
localparam int K_AND  = 2;
localparam int K_OR   = 3;
localparam int K_XOR  = 4;
localparam int K_SLT  = 5;
localparam int K_ADDI = 6;
localparam int K_ANDI = 7;
localparam int K_ORI  = 8;
localparam int K_XORI = 9;
localparam int K_LUI  = 10;
localparam int K_MUL  = 11;
localparam int K_ILL  = 12;

data_t     arch_regs [32];
logic      exp_pending [16];
logic      exp_is_exc [16];
reg_addr_t exp_rd [16];
data_t     exp_data [16];
inst_t     exp_inst [16];

function automatic void reset_model();
    for (int i = 0; i < 32; i++)
        arch_regs[i] = '0;
    for (int i = 0; i < 16; i++) begin
        exp_pending[i] = 1'b0;
        exp_is_exc[i]  = 1'b0;
    end
endfunction

function automatic data_t compute_result(int kind, data_t a, data_t b, logic [19:0] imm);
    data_t imm_i;
    imm_i = {{20{imm[11]}}, imm[11:0]};
    case (kind)
        K_ADD:   return a + b;
        K_SUB:   return a - b;
        K_AND:   return a & b;
        K_OR:    return a | b;
        K_XOR:   return a ^ b;
        K_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_ADDI:  return a + imm_i;
        K_ANDI:  return a & imm_i;
        K_ORI:   return a | imm_i;
        K_XORI:  return a ^ imm_i;
        K_LUI:   return {imm, 12'b0};
        // Low word of the product
        default: return a * b;
    endcase
endfunction

// Runs one instruction in order and files what the DUT must return for it
function automatic void record_expected(int kind, reg_addr_t rd, reg_addr_t rs1,
                                        reg_addr_t rs2, logic [19:0] imm,
                                        inst_id_t id, inst_t word);
    data_t res;
    exp_pending[id] = 1'b1;
    exp_inst[id]    = word;
    exp_is_exc[id]  = (kind == K_ILL);
    if (kind != K_ILL) begin
        res          = compute_result(kind, arch_regs[rs1], arch_regs[rs2], imm);
        exp_rd[id]   = rd;
        exp_data[id] = res;
        // x0 keeps its zero
        if (rd != 5'd0)
            arch_regs[rd] = res;
    end
endfunction

`endif

// ==== verif/issue_tb.sv ====
// Testbench for the decode and issue stage
// Random RV32 stream with hazards and illegal encodings, checked against an in-order model

`timescale 1ns/1ps

module issue_tb import issue_pkg::*; ();

    localparam int          CREDITS     = 4;
    localparam int          NUM_INIT    = 7;
    localparam int          NUM_RANDOM  = 300;
    localparam int          NUM_TOTAL   = NUM_INIT + NUM_RANDOM;
    localparam logic [31:0] SEED        = 32'h8754_355b;
    localparam logic [3:0]  EXC_ILLEGAL = 4'd2;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    inst_t     inst;
    inst_id_t  inst_id;
    logic [31:0] inst_pc;
    logic      exc_ack;
    logic      inst_credit;
    logic      wb_valid;
    reg_addr_t wb_rd;
    inst_id_t  wb_id;
    data_t     wb_data;
    logic      exc_valid;
    exc_code_t exc_code;
    inst_id_t  exc_id;
    data_t     exc_tval;

    int credits;
    int errors;
    int checks;
    int sent;
    int done_cnt;

    `include "issue_model.svh"

    issue_top #(.DECODE_CREDITS(CREDITS)) u_dut (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_id     (inst_id),
        .inst_pc     (inst_pc),
        .exc_ack     (exc_ack),
        .inst_credit (inst_credit),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_id       (wb_id),
        .wb_data     (wb_data),
        .exc_valid   (exc_valid),
        .exc_code    (exc_code),
        .exc_id      (exc_id),
        .exc_tval    (exc_tval)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic inst_t encode_inst(int kind, reg_addr_t rd, reg_addr_t rs1,
                                          reg_addr_t rs2, logic [19:0] imm);
        case (kind)
            K_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_MUL:  return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ANDI: return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            K_ORI:  return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            K_XORI: return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            K_LUI:  return {imm, rd, 7'b0110111};
            default: begin
                // SLTI, SLL, LW and DIV are outside the supported set
                case (imm[1:0])
                    2'd0:    return {imm[11:0], rs1, 3'b010, rd, 7'b0010011};
                    2'd1:    return {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
                    2'd2:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
                    default: return {7'b0000001, rs2, rs1, 3'b100, rd, 7'b0110011};
                endcase
            end
        endcase
    endfunction

    task automatic check_writeback();
        inst_id_t id;
        id = wb_id;
        check_value("writeback id outstanding", {31'b0, exp_pending[id]}, 32'd1);
        check_value("writeback from illegal instruction", {31'b0, exp_is_exc[id]}, 32'd0);
        check_value("writeback rd", {27'b0, wb_rd}, {27'b0, exp_rd[id]});
        check_value("writeback data", wb_data, exp_data[id]);
        exp_pending[id] = 1'b0;
        done_cnt++;
    endtask

    //////////////////////////////
    // Monitors sample mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (inst_credit)
                credits++;
            check_value("credit count in range", {31'b0, credits >= 0 && credits <= CREDITS},
                        32'd1);
            if (wb_valid)
                check_writeback();
        end
    end

    // Exception checker and delayed acknowledge
    initial begin : exc_responder
        int delay;
        forever begin
            @(negedge clk);
            if (!rst && exc_valid) begin
                check_value("exception id outstanding", {31'b0, exp_pending[exc_id]}, 32'd1);
                check_value("exception on legal instruction", {31'b0, exp_is_exc[exc_id]},
                            32'd1);
                check_value("exception code", {28'b0, exc_code}, {28'b0, EXC_ILLEGAL});
                check_value("exception tval", exc_tval, exp_inst[exc_id]);
                exp_pending[exc_id] = 1'b0;
                done_cnt++;
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1 exc_ack = 1'b1;
                @(posedge clk);
                #1 exc_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_TOTAL * 20) @(posedge clk);
        $display("Watchdog expired with %0d of %0d instructions finished", done_cnt, sent);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    initial begin : stimulus
        inst_t       word;
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [19:0] imm;
        inst_id_t    id;
        void'($urandom(SEED));
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        inst_id    = '0;
        inst_pc    = '0;
        exc_ack    = 1'b0;
        credits    = CREDITS;
        errors     = 0;
        checks     = 0;
        sent       = 0;
        done_cnt   = 0;
        reset_model();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        for (int n = 0; n < NUM_TOTAL; n++) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            id = n[3:0];
            // Occasional idle cycle between sends
            if ($urandom % 8 == 0) begin
                @(posedge clk);
                #1;
            end
            while (credits == 0 || exp_pending[id]) begin
                @(posedge clk);
                #1;
            end
            imm = 20'($urandom);
            rs1 = 5'($urandom % 8);
            rs2 = 5'($urandom % 8);
            rd  = 5'($urandom % 8);
            if (n < NUM_INIT) begin
                // Known values in x1..x7 before any random read
                kind = K_ADDI;
                rd   = 5'(n + 1);
                rs1  = 5'd0;
            end else if ($urandom % 100 < 5) begin
                kind = K_ILL;
            end else begin
                kind = $urandom % 12;
            end
            word = encode_inst(kind, rd, rs1, rs2, imm);
            record_expected(kind, rd, rs1, rs2, imm, id, word);
            inst_valid = 1'b1;
            inst       = word;
            inst_id    = id;
            inst_pc    = 32'(n * 4);
            credits--;
            sent++;
        end
        @(posedge clk);
        #1 inst_valid = 1'b0;

        // Drain and make sure nothing extra arrives
        wait (done_cnt == sent);
        repeat (10) @(posedge clk);
        check_value("credits returned", credits, CREDITS);
        check_value("results plus exceptions", done_cnt, sent);

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== issue_top.f ====
+incdir+verif
common/issue_pkg.sv
logic/inst_buffer.sv
issue/decode_and_issue.sv
issue/reg_scoreboard.sv
logic/regfile.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/issue_top.sv
verif/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode and issue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f issue_top.f \
    --top-module issue_tb \
    -o issue_sim

./obj_dir/issue_sim | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1
